//--- Bender.yml
package:
  name: fifo_top

sources:
  # synthesizable design, package first
  - files:
      - rtl/fifo_pkg.sv
      - rtl/fifo_wr_ctrl.sv
      - rtl/fifo_mem.sv
      - rtl/fifo_rd_ctrl.sv
      - rtl/fifo_top.sv

  # testbench, top module fifo_tb
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/fifo_tb.sv

//--- fifo_top.f
rtl/fifo_pkg.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_mem.sv
rtl/fifo_rd_ctrl.sv
rtl/fifo_top.sv
verif/tb_clk_gen.sv
verif/fifo_tb.sv

//--- rtl/fifo_mem.sv
// fifo storage array

`timescale 1ns/1ns

module fifo_mem
(
    input  logic             rclk,
    input  logic             wr_en,     // store strobe
    input  fifo_pkg::addr_t  wr_addr,
    input  fifo_pkg::data_t  wr_data,
    input  fifo_pkg::addr_t  rd_addr,
    output fifo_pkg::data_t  rd_data    // same cycle read
);

    //**********************************************************************
    // register array
    //**********************************************************************
    fifo_pkg::data_t mem [fifo_pkg::DEPTH];   // DEPTH words, no reset

    // write port, one word per edge
    always_ff @(posedge rclk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // read port is combinational
    // read side loads its holding register on the pop edge
    assign rd_data = mem[rd_addr];

endmodule

//--- rtl/fifo_pkg.sv
// fifo shared constants and types
// single clock pointer fifo

package fifo_pkg;

    //**********************************************************************
    // geometry
    //**********************************************************************
    localparam int ADDR_W = 4;               // storage address bits
    localparam int DEPTH  = 1 << ADDR_W;     // 16 words of storage
    localparam int DATA_W = 32;              // stream word width

    // watermarks, compared against the storage level
    localparam int ALMOST_FULL_NUM  = 12;    // almost_full at or above
    localparam int ALMOST_EMPTY_NUM = 2;     // almost_empty at or below

    //**********************************************************************
    // types
    //**********************************************************************
    typedef logic [DATA_W-1:0] data_t;       // one stream word
    typedef logic [ADDR_W:0]   ptr_t;        // address plus wrap bit
    typedef logic [ADDR_W-1:0] addr_t;       // storage index
    typedef logic [ADDR_W:0]   level_t;      // 0 .. DEPTH inclusive

    // status word seen outside
    // level, almost_full, full from write side
    // almost_empty, empty from read side
    typedef struct packed {
        level_t level;          // words held in storage
        logic   almost_full;
        logic   almost_empty;
        logic   full;           // storage cannot take a word
        logic   empty;          // storage has nothing to pop
    } fifo_status_t;

endpackage

//--- rtl/fifo_rd_ctrl.sv
// fifo read side
// read pointer, empty flags, output holding register

`timescale 1ns/1ns

module fifo_rd_ctrl
(
    input  logic              rclk,
    input  logic              rrst,
    input  logic              out_ready,    // consumer takes the word
    input  fifo_pkg::ptr_t    wr_ptr_next,  // from write side, next state
    input  fifo_pkg::data_t   rd_data,      // storage word at rd_addr
    output fifo_pkg::addr_t   rd_addr,
    output fifo_pkg::ptr_t    rd_ptr_next,  // to write side
    output logic              out_valid,    // holding register loaded
    output fifo_pkg::data_t   out_data,
    output logic              empty,
    output logic              almost_empty
);

    //**********************************************************************
    // locals
    //**********************************************************************
    fifo_pkg::ptr_t   rd_ptr;       // current read pointer
    fifo_pkg::level_t rd_level;     // own view of storage occupancy
    logic             pop;          // move one word storage -> holding

    //**********************************************************************
    // pop decision
    //**********************************************************************
    // holding register free, or emptied at this same edge
    assign pop = ~empty & (~out_valid | out_ready);

    always_comb
    begin
        if (pop)
            rd_ptr_next = rd_ptr + fifo_pkg::ptr_t'(1);
        else
            rd_ptr_next = rd_ptr;
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            rd_ptr <= '0;
        else
            rd_ptr <= rd_ptr_next;
    end

    assign rd_addr = rd_ptr[fifo_pkg::ADDR_W-1:0];   // address part only

    //**********************************************************************
    // flags from next state pointers
    //**********************************************************************
    assign rd_level = wr_ptr_next - rd_ptr_next;     // wraps cleanly

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            empty        <= 1'b1;    // nothing stored yet
            almost_empty <= 1'b1;
        end
        else
        begin
            empty        <= (wr_ptr_next == rd_ptr_next);
            almost_empty <= (rd_level <= fifo_pkg::ALMOST_EMPTY_NUM);
        end
    end

    //**********************************************************************
    // output holding register
    //**********************************************************************
    // valid is control state
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            out_valid <= 1'b0;
        else if (pop)
            out_valid <= 1'b1;           // refilled, maybe same edge as take
        else if (out_ready)
            out_valid <= 1'b0;           // taken, nothing behind it
    end

    // payload only moves on a pop, so it holds under back-pressure
    always_ff @(posedge rclk)
    begin
        if (pop)
            out_data <= rd_data;
    end

endmodule

//--- rtl/fifo_top.sv
// fifo subsystem top
// write side, storage, read side

`timescale 1ns/1ns

module fifo_top
(
    input  logic                    rclk,
    input  logic                    rrst,
    // input stream
    input  logic                    in_valid,
    input  fifo_pkg::data_t         in_data,
    output logic                    in_ready,
    // output stream
    output logic                    out_valid,
    output fifo_pkg::data_t         out_data,
    input  logic                    out_ready,
    // flags and level
    output fifo_pkg::fifo_status_t  status
);

    //**********************************************************************
    // internal nets
    //**********************************************************************
    logic              wr_en;
    fifo_pkg::addr_t   wr_addr;
    fifo_pkg::addr_t   rd_addr;
    fifo_pkg::data_t   rd_data;
    fifo_pkg::ptr_t    wr_ptr_next;   // write side -> read side
    fifo_pkg::ptr_t    rd_ptr_next;   // read side -> write side
    fifo_pkg::level_t  level;
    logic              almost_full;
    logic              full;
    logic              almost_empty;
    logic              empty;

    //**********************************************************************
    // blocks
    //**********************************************************************
    fifo_wr_ctrl i_fifo_wr_ctrl
    (
        .rclk        (rclk),
        .rrst        (rrst),
        .in_valid    (in_valid),
        .rd_ptr_next (rd_ptr_next),
        .in_ready    (in_ready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_ptr_next (wr_ptr_next),
        .level       (level),
        .almost_full (almost_full),
        .full        (full)
    );

    // in_data goes straight into storage
    fifo_mem i_fifo_mem
    (
        .rclk    (rclk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (in_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fifo_rd_ctrl i_fifo_rd_ctrl
    (
        .rclk         (rclk),
        .rrst         (rrst),
        .out_ready    (out_ready),
        .wr_ptr_next  (wr_ptr_next),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .rd_ptr_next  (rd_ptr_next),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .empty        (empty),
        .almost_empty (almost_empty)
    );

    //**********************************************************************
    // status word
    //**********************************************************************
    assign status.level        = level;          // storage only, not holding reg
    assign status.almost_full  = almost_full;
    assign status.almost_empty = almost_empty;
    assign status.full         = full;
    assign status.empty        = empty;

endmodule

//--- rtl/fifo_wr_ctrl.sv
// fifo write side
// write pointer, full flag, level and almost full

`timescale 1ns/1ns

module fifo_wr_ctrl
(
    input  logic              rclk,
    input  logic              rrst,
    input  logic              in_valid,     // producer has a word
    input  fifo_pkg::ptr_t    rd_ptr_next,  // from read side, next state
    output logic              in_ready,     // room in storage
    output logic              wr_en,        // store strobe to fifo_mem
    output fifo_pkg::addr_t   wr_addr,
    output fifo_pkg::ptr_t    wr_ptr_next,  // to read side
    output fifo_pkg::level_t  level,        // storage occupancy
    output logic              almost_full,
    output logic              full
);

    //**********************************************************************
    // locals
    //**********************************************************************
    fifo_pkg::ptr_t   wr_ptr;       // current write pointer
    fifo_pkg::level_t level_next;   // occupancy after this edge
    logic             full_next;

    //**********************************************************************
    // handshake and pointer advance
    //**********************************************************************
    assign in_ready = ~full;                 // registered flag only, no loop
    assign wr_en    = in_valid & ~full;      // accepted word

    // wrap bit counts laps, so +1 past DEPTH-1 flips it
    always_comb
    begin
        if (wr_en)
            wr_ptr_next = wr_ptr + fifo_pkg::ptr_t'(1);
        else
            wr_ptr_next = wr_ptr;
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            wr_ptr <= '0;
        else
            wr_ptr <= wr_ptr_next;
    end

    assign wr_addr = wr_ptr[fifo_pkg::ADDR_W-1:0];   // drop wrap bit

    //**********************************************************************
    // flags from next state pointers
    //**********************************************************************
    // same address, other lap -> storage full
    assign full_next =
        (wr_ptr_next[fifo_pkg::ADDR_W] != rd_ptr_next[fifo_pkg::ADDR_W]) &&
        (wr_ptr_next[fifo_pkg::ADDR_W-1:0] == rd_ptr_next[fifo_pkg::ADDR_W-1:0]);

    // modulo 2*DEPTH difference gives 0..DEPTH directly
    assign level_next = wr_ptr_next - rd_ptr_next;

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            full        <= 1'b0;
            level       <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            full        <= full_next;
            level       <= level_next;
            // compared on next level so it moves with level
            almost_full <= (level_next >= fifo_pkg::ALMOST_FULL_NUM);
        end
    end

endmodule

//--- verif/fifo_tb.sv
// fifo subsystem testbench
// queue model, per edge comparison, stream traffic

`timescale 1ns/1ns

module fifo_tb;

    //**********************************************************************
    // constants and DUT nets
    //**********************************************************************
    localparam int unsigned SEED = 32'h9b81c035;
    localparam int WAIT_LIMIT  = 64;    // cycles for a single handshake
    localparam int DRAIN_LIMIT = 400;   // cycles to empty a full fifo

    logic                   rclk;
    logic                   rrst;
    logic                   in_valid;
    fifo_pkg::data_t        in_data;
    logic                   in_ready;
    logic                   out_valid;
    fifo_pkg::data_t        out_data;
    logic                   out_ready;
    fifo_pkg::fifo_status_t status;

    // model and bookkeeping
    fifo_pkg::data_t  model_q[$];       // accepted but not yet consumed
    fifo_pkg::level_t exp_level;
    int               held;
    logic             accepted_last = 1'b0;   // handshake at last edge
    logic             check_on = 1'b0;
    int               words_in = 0;
    int               words_out = 0;
    int               value_errs = 0;
    int               other_errs = 0;

    tb_clk_gen i_tb_clk_gen
    (
        .rclk (rclk),
        .rrst (rrst)
    );

    fifo_top i_fifo_top
    (
        .rclk      (rclk),
        .rrst      (rrst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .status    (status)
    );

    //**********************************************************************
    // reference model and error reporting
    //**********************************************************************
    // storage words = all held words minus the one in the output register
    function automatic fifo_pkg::level_t storage_count(input int total, input logic holding);
        int n;
        n = holding ? total - 1 : total;
        if (n < 0)
            n = 0;
        if (n > fifo_pkg::DEPTH)
            n = fifo_pkg::DEPTH;       // storage cannot hold more
        return fifo_pkg::level_t'(n);
    endfunction

    // oldest word not yet consumed
    function automatic fifo_pkg::data_t head_word();
        if (model_q.size() == 0)
            return '0;
        return model_q[0];
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                   input logic [63:0] got_v);
        $display("FAILED at %0t ns: %s expected %0h got %0h", $time, sig, exp_v, got_v);
        value_errs++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        other_errs++;
    endtask

    //**********************************************************************
    // comparison on every rising edge with pre-edge values
    //**********************************************************************
    always @(posedge rclk)
    begin
        if (!rrst && check_on)
        begin
            held      = model_q.size();
            exp_level = storage_count(held, out_valid);
            // flags follow the storage level exactly
            if (status.level !== exp_level)
                report_mismatch("status.level", exp_level, status.level);
            if (status.empty !== (exp_level == 0))
                report_mismatch("status.empty", exp_level == 0, status.empty);
            if (status.full !== (exp_level == fifo_pkg::DEPTH))
                report_mismatch("status.full", exp_level == fifo_pkg::DEPTH, status.full);
            if (status.almost_full !== (exp_level >= fifo_pkg::ALMOST_FULL_NUM))
                report_mismatch("status.almost_full",
                                exp_level >= fifo_pkg::ALMOST_FULL_NUM, status.almost_full);
            if (status.almost_empty !== (exp_level <= fifo_pkg::ALMOST_EMPTY_NUM))
                report_mismatch("status.almost_empty",
                                exp_level <= fifo_pkg::ALMOST_EMPTY_NUM, status.almost_empty);
            if (in_ready !== (exp_level != fifo_pkg::DEPTH))
                report_mismatch("in_ready", exp_level != fifo_pkg::DEPTH, in_ready);
            if (out_valid && held == 0)
                report_problem("out_valid high although no word is held");
            if (!out_valid && held >= 2)
                report_problem("out_valid low while words are waiting");
            // holding register shows the oldest word and keeps it under stall
            if (out_valid && held > 0 && out_data !== head_word())
                report_mismatch("out_data", head_word(), out_data);
            if (out_valid && out_ready && held > 0)
            begin
                model_q.delete(0);
                words_out++;
            end
            accepted_last = in_valid && in_ready;
            if (accepted_last)
            begin
                model_q.push_back(in_data);
                words_in++;
            end
        end
    end

    //**********************************************************************
    // stimulus tasks entered and left on a falling edge
    //**********************************************************************
    task automatic send_word(input fifo_pkg::data_t w);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_data  = w;
        @(posedge rclk);
        while (!in_ready && waited < WAIT_LIMIT)
        begin
            @(posedge rclk);
            waited++;
        end
        if (!in_ready)
            report_problem("word never accepted at the input");
        @(negedge rclk);
        in_valid = 1'b0;
    endtask

    // one word into an idle fifo shows up one edge after acceptance
    task automatic check_latency();
        int waited;
        int edges_after;
        waited      = 0;
        edges_after = 0;
        out_ready   = 1'b0;
        in_valid    = 1'b1;
        in_data     = $urandom;
        @(posedge rclk);
        while (!in_ready && waited < WAIT_LIMIT)
        begin
            @(posedge rclk);
            waited++;
        end
        if (!in_ready)
            report_problem("latency word never accepted");
        @(negedge rclk);                // after acceptance edge
        in_valid = 1'b0;
        if (out_valid)
            report_problem("out_valid high right after the acceptance edge");
        while (!out_valid && edges_after < WAIT_LIMIT)
        begin
            @(negedge rclk);
            edges_after++;
        end
        if (!out_valid)
            report_problem("latency word never reached the output");
        else if (edges_after != 1)
            report_mismatch("out_valid latency", 1, edges_after);
    endtask

    // consumer stalled so storage and holding register both fill
    task automatic fill_while_stalled();
        int start;
        start     = words_in;
        out_ready = 1'b0;
        for (int i = 0; i < fifo_pkg::DEPTH + 1; i++)
            send_word($urandom);
        in_valid = 1'b1;                // one more offer that must not get in
        in_data  = $urandom;
        for (int i = 0; i < 4; i++)
        begin
            @(posedge rclk);
            if (in_ready)
                report_problem("word accepted beyond capacity");
        end
        @(negedge rclk);
        in_valid = 1'b0;
        if (words_in - start != fifo_pkg::DEPTH + 1)
            report_mismatch("accepted words", fifo_pkg::DEPTH + 1, words_in - start);
        if (status.full !== 1'b1)
            report_mismatch("status.full", 1, status.full);
        if (in_ready !== 1'b0)
            report_mismatch("in_ready", 0, in_ready);
        if (status.level !== fifo_pkg::level_t'(fifo_pkg::DEPTH))
            report_mismatch("status.level", fifo_pkg::DEPTH, status.level);
    endtask

    task automatic random_traffic(input int cycles, input int valid_pct, input int ready_pct);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge rclk);
            // a pending offer keeps valid and data
            if (!in_valid || accepted_last)
            begin
                in_valid = ($urandom % 100) < valid_pct;
                in_data  = $urandom;
            end
            out_ready = ($urandom % 100) < ready_pct;
        end
    endtask

    task automatic drain_all();
        int waited;
        waited    = 0;
        out_ready = 1'b1;
        while (in_valid && !accepted_last && waited < WAIT_LIMIT)   // finish offer
        begin
            @(negedge rclk);
            waited++;
        end
        in_valid = 1'b0;
        waited   = 0;
        while ((model_q.size() != 0 || out_valid) && waited < DRAIN_LIMIT)
        begin
            @(negedge rclk);
            waited++;
        end
        if (model_q.size() != 0 || out_valid)
            report_problem("fifo did not drain");
        if (status.empty !== 1'b1)
            report_mismatch("status.empty", 1, status.empty);
        if (out_valid !== 1'b0)
            report_mismatch("out_valid", 0, out_valid);
        if (status.level !== '0)
            report_mismatch("status.level", 0, status.level);
        out_ready = 1'b0;
    endtask

    //**********************************************************************
    // main sequence
    //**********************************************************************
    initial
    begin : main_seq
        int waited;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        waited    = 0;
        void'($urandom(SEED));
        @(posedge rclk);
        while (rrst && waited < 20)
        begin
            @(posedge rclk);
            waited++;
        end
        if (rrst)
            report_problem("reset never released");
        // idle state straight after reset
        if (out_valid !== 1'b0)
            report_mismatch("out_valid", 0, out_valid);
        if (in_ready !== 1'b1)
            report_mismatch("in_ready", 1, in_ready);
        if (status.empty !== 1'b1)
            report_mismatch("status.empty", 1, status.empty);
        if (status.almost_empty !== 1'b1)
            report_mismatch("status.almost_empty", 1, status.almost_empty);
        if (status.full !== 1'b0)
            report_mismatch("status.full", 0, status.full);
        if (status.level !== '0)
            report_mismatch("status.level", 0, status.level);
        @(negedge rclk);
        check_on = 1'b1;

        check_latency();
        drain_all();
        fill_while_stalled();
        drain_all();
        random_traffic(300, 70, 30);    // mostly filling
        random_traffic(300, 40, 80);    // mostly draining
        random_traffic(150, 90, 90);    // near full rate both sides
        drain_all();

        if (words_in != words_out)
            report_problem("words in and words out differ");
        $display("summary: %0d words in, %0d words out, %0d value errors, %0d other errors",
                 words_in, words_out, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
// testbench clock and reset

`timescale 1ns/1ns

module tb_clk_gen
(
    output logic rclk,
    output logic rrst
);

    localparam int PERIOD       = 40;   // ns
    localparam int RESET_CYCLES = 3;

    initial
    begin
        rclk = 1'b0;                    // first rising edge at PERIOD/2
        forever #(PERIOD/2) rclk = ~rclk;
    end

    // released on a falling edge, away from the active edge
    initial
    begin
        rrst = 1'b1;
        #(RESET_CYCLES*PERIOD) rrst = 1'b0;
    end

endmodule
